//--- common/sensors_macros.svh
// ~~~~~~~~~~~~~~~~~~~~
// sensor subsystem constants
// address map, mode bit positions, counter widths and reset defaults
// shared by the command decode, frame sync and status blocks
// ~~~~~~~~~~~~~~~~~~~~
`ifndef SENSORS_MACROS_SVH
`define SENSORS_MACROS_SVH

// command port address map
`define SENSOR_GROUP_ADDR    'h400   // first sensor register
`define SENSOR_BASE_INC      'h40    // window per channel
`define SENSOR_CTRL_REL      0       // mode word
`define SENS_SYNC_MULT_REL   'h6     // frames to combine, minus one
`define SENS_SYNC_LATE_REL   'h7     // lines before late sof

// frame sync
`define SENS_SYNC_LATE_DFLT  15      // late line count out of reset
`define SENS_SYNC_BITS       16      // counts and frame counter

// status reporting
`define STATUS_REG_BASE      'h20    // channel 0 status address
`define STATUS_REG_INC       2       // step between channels
`define STATUS_PKT_BYTES     4       // addr + 3 payload bytes

// command framing
`define CMD_BYTES            6       // AL, AH, D0..D3

// mode word bits
`define SENSOR_CHN_EN_BIT    8       // channel enable
`define SENSOR_16BIT_BIT     9       // 16 bpp, stored and reported only

// channel count
`define NUM_SENSORS          4

`endif

//--- common/sensors_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// sensor subsystem types
// mode word layout and the two views of a command data word
// ~~~~~~~~~~~~~~~~~~~~
`include "sensors_macros.svh"

package sensors_pkg;

    // per-channel mode register
    typedef struct packed {
        logic [30-`SENSOR_16BIT_BIT:0] rsv_hi;  // [31:10] unused
        logic                          bpp16;   // bit 9
        logic                          chn_en;  // bit 8
        logic [`SENSOR_CHN_EN_BIT-1:0] rsv_lo;  // [7:0] unused
    } sensor_mode_t;

    // count register view, value in the low half
    typedef struct packed {
        logic [31-`SENS_SYNC_BITS:0] rsv;       // ignored on write
        logic [`SENS_SYNC_BITS-1:0]  cnt;       // mult or late
    } cmd_count_t;

    // one command data word, decoded by target register
    typedef union packed {
        sensor_mode_t mode;                     // SENSOR_CTRL_REL
        cmd_count_t   count;                    // MULT / LATE
    } cmd_data_u;

endpackage

//--- source/cmd_deser.sv
// ~~~~~~~~~~~~~~~~~~~~
// command deserializer
// collects six bytes of the byte-serial command port into an
// address and a data word, then issues a single write strobe
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sensors_macros.svh"

module cmd_deser
    import sensors_pkg::*;
(
    input  logic        mclk,
    input  logic        rst,
    input  logic [7:0]  cmd_ad_in,    // AL, AH, D0, D1, D2, D3
    input  logic        cmd_stb_in,   // marks AL only
    output logic        wr_stb,       // one cycle, all channels
    output logic [15:0] wr_addr,
    output cmd_data_u   wr_data
);
    localparam int               CNT_W = $clog2(`CMD_BYTES + 1);
    localparam logic [CNT_W-1:0] LAST  = CNT_W'(`CMD_BYTES);  // all bytes in

    logic [7:0]              cmd_ad_r;   // input register
    logic                    cmd_stb_r;
    logic [CNT_W-1:0]        byte_cnt;   // 0 idle, 1..5 collecting, LAST done
    logic [CNT_W-1:0]        byte_idx;   // slot for the current byte
    logic                    collect;
    logic [8*`CMD_BYTES-1:0] cmd_asm;    // assembled command, AL in [7:0]

    assign byte_idx = cmd_stb_r ? '0 : byte_cnt;
    assign collect  = cmd_stb_r || ((byte_cnt != '0) && (byte_cnt != LAST));

    always_ff @(posedge mclk) begin
        cmd_ad_r <= cmd_ad_in;            // payload, no reset
        if (rst) begin
            cmd_stb_r <= 1'b0;
        end else begin
            cmd_stb_r <= cmd_stb_in;
        end
    end

    always_ff @(posedge mclk) begin
        if (collect) begin
            cmd_asm[8*byte_idx +: 8] <= cmd_ad_r;
        end
        if (byte_cnt == LAST) begin       // copy out, frees cmd_asm for next
            wr_addr <= cmd_asm[15:0];
            wr_data <= cmd_data_u'(cmd_asm[8*`CMD_BYTES-1:16]);
        end
    end

    always_ff @(posedge mclk) begin
        if (rst) begin
            byte_cnt <= '0;
            wr_stb   <= 1'b0;
        end else begin
            wr_stb <= (byte_cnt == LAST);
            if (cmd_stb_r) begin
                byte_cnt <= CNT_W'(1);    // AL stored this edge
            end else if (byte_cnt == LAST) begin
                byte_cnt <= '0;
            end else if (byte_cnt != '0) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // no back-pressure here, a second strobe must wait for the sixth byte
    a_no_stb_mid_cmd: assert property (@(posedge mclk) disable iff (rst)
        cmd_stb_r |-> ((byte_cnt == '0) || (byte_cnt == LAST)))
        else $error("cmd_deser: strobe inside a command");

endmodule

//--- sensor_channel/sensor_sync.sv
// ~~~~~~~~~~~~~~~~~~~~
// sensor frame sync
// channel registers, trigger divider combining mult+1 triggers
// into one frame, late sof after a number of lines, frame counter
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sensors_macros.svh"

module sensor_sync
    import sensors_pkg::*;
#(
    parameter int CHN_NUM = 0            // 0..3, picks the register window
) (
    input  logic                       mclk,
    input  logic                       rst,
    input  logic                       wr_stb,
    input  logic [15:0]                wr_addr,
    input  cmd_data_u                  wr_data,
    input  logic                       trig_in,    // single-cycle pulse
    input  logic                       line_stb,   // single-cycle pulse
    output logic                       sof_out,
    output logic                       sof_late,
    output logic [`SENS_SYNC_BITS-1:0] frame_cnt,
    output sensor_mode_t               mode
);
    localparam logic [15:0] BASE_ADDR = 16'(`SENSOR_GROUP_ADDR + CHN_NUM * `SENSOR_BASE_INC);
    localparam logic [15:0] CTRL_ADDR = BASE_ADDR + 16'(`SENSOR_CTRL_REL);
    localparam logic [15:0] MULT_ADDR = BASE_ADDR + 16'(`SENS_SYNC_MULT_REL);
    localparam logic [15:0] LATE_ADDR = BASE_ADDR + 16'(`SENS_SYNC_LATE_REL);

    logic [`SENS_SYNC_BITS-1:0] mult;      // frames to combine minus 1
    logic [`SENS_SYNC_BITS-1:0] late;      // lines from sof to sof_late
    logic [`SENS_SYNC_BITS-1:0] div_cnt;   // triggers since last sof
    logic [`SENS_SYNC_BITS-1:0] line_cnt;  // lines still to wait
    logic                       pending;   // waiting for lines
    logic                       sof_fire;
    logic                       sof_seen;  // a sof since enable

    assign sof_fire = mode.chn_en && trig_in && (div_cnt == '0);

    // register writes, window decode per channel
    always_ff @(posedge mclk) begin
        if (rst) begin
            mode <= '0;
            mult <= '0;
            late <= `SENS_SYNC_BITS'(`SENS_SYNC_LATE_DFLT);
        end else if (wr_stb) begin
            if (wr_addr == CTRL_ADDR) mode <= wr_data.mode;
            if (wr_addr == MULT_ADDR) mult <= wr_data.count.cnt;
            if (wr_addr == LATE_ADDR) late <= wr_data.count.cnt;
        end
    end

    // trigger divider and frame counter
    always_ff @(posedge mclk) begin
        if (rst) begin
            div_cnt   <= '0;
            sof_out   <= 1'b0;
            frame_cnt <= '0;
            sof_seen  <= 1'b0;
        end else begin
            sof_out <= sof_fire;
            if (!mode.chn_en) begin
                div_cnt  <= '0;                         // held while disabled
                sof_seen <= 1'b0;
            end else if (trig_in) begin
                div_cnt <= (div_cnt >= mult) ? '0 : div_cnt + 1'b1;
            end
            if (sof_out && mode.chn_en) sof_seen <= 1'b1;   // from the issued pulse
            if (sof_fire) frame_cnt <= frame_cnt + 1'b1;  // visible with sof_out
        end
    end

    // late frame sync, restarted by every sof
    always_ff @(posedge mclk) begin
        if (rst) begin
            pending  <= 1'b0;
            line_cnt <= '0;
            sof_late <= 1'b0;
        end else begin
            sof_late <= 1'b0;
            if (!mode.chn_en) begin
                pending  <= 1'b0;                       // drop a stale count
            end else if (sof_fire) begin
                if (late == '0) begin
                    sof_late <= 1'b1;                   // same cycle as sof_out
                    pending  <= 1'b0;
                end else begin
                    pending  <= 1'b1;
                    line_cnt <= late;
                end
            end else if (pending && line_stb) begin
                line_cnt <= line_cnt - 1'b1;
                if (line_cnt == `SENS_SYNC_BITS'(1)) begin  // late-th line
                    sof_late <= 1'b1;
                    pending  <= 1'b0;
                end
            end
        end
    end

    a_late_after_sof: assert property (@(posedge mclk) disable iff (rst)
        sof_late |-> (sof_out || sof_seen))
        else $error("sensor_sync %0d: sof_late before first sof", CHN_NUM);

endmodule

//--- sensor_channel/sensor_status.sv
// ~~~~~~~~~~~~~~~~~~~~
// sensor status sender
// latches frame count and mode flags on late sof, then sends a
// four-byte packet on the byte-serial status port
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sensors_macros.svh"

module sensor_status
    import sensors_pkg::*;
#(
    parameter int CHN_NUM = 0              // 0..3, picks the status address
) (
    input  logic                       mclk,
    input  logic                       rst,
    input  logic                       sof_late,
    input  logic [`SENS_SYNC_BITS-1:0] frame_cnt,
    input  sensor_mode_t               mode,
    output logic [7:0]                 status_ad,     // addr, then payload
    output logic                       status_rq,
    input  logic                       status_start   // addr byte taken
);
    localparam logic [7:0] STATUS_ADDR = 8'(`STATUS_REG_BASE + `STATUS_REG_INC * CHN_NUM);
    localparam logic [1:0] LAST_BYTE   = 2'(`STATUS_PKT_BYTES - 1);

    logic [`SENS_SYNC_BITS-1:0] cnt_lat;    // frame count snapshot
    logic [1:0]                 flags_lat;  // {bpp16, chn_en}
    logic                       busy;       // streaming bytes 2..4
    logic [1:0]                 byte_sel;   // byte now on status_ad
    logic                       take;
    logic                       latch;

    assign take  = status_rq && status_start;
    assign latch = sof_late && mode.chn_en && !busy && !take;  // refresh until started

    always_ff @(posedge mclk) begin
        if (latch) begin
            cnt_lat   <= frame_cnt;
            flags_lat <= {mode.bpp16, mode.chn_en};
        end
    end

    always_ff @(posedge mclk) begin
        if (rst) begin
            status_rq <= 1'b0;
            busy      <= 1'b0;
            byte_sel  <= '0;
        end else if (busy) begin
            byte_sel <= byte_sel + 1'b1;
            if (byte_sel == LAST_BYTE) begin
                busy     <= 1'b0;
                byte_sel <= '0;                  // back to address
            end
        end else if (take) begin
            status_rq <= 1'b0;
            busy      <= 1'b1;
            byte_sel  <= 2'd1;
        end else if (latch) begin
            status_rq <= 1'b1;
        end
    end

    always_comb begin
        case (byte_sel)
            2'd0:    status_ad = STATUS_ADDR;
            2'd1:    status_ad = cnt_lat[7:0];
            2'd2:    status_ad = cnt_lat[15:8];
            default: status_ad = {6'b0, flags_lat};
        endcase
    end

    // start comes through the router, only for a live request
    a_start_with_rq: assert property (@(posedge mclk) disable iff (rst)
        status_start |-> status_rq)
        else $error("sensor_status %0d: start without request", CHN_NUM);

endmodule

//--- source/status_router4.sv
// ~~~~~~~~~~~~~~~~~~~~
// status router
// round-robin merge of four byte-serial status streams onto one,
// grant held for a whole packet
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sensors_macros.svh"

module status_router4 (
    input  logic                         mclk,
    input  logic                         rst,
    input  logic [`NUM_SENSORS-1:0][7:0] db_in,
    input  logic [`NUM_SENSORS-1:0]      rq_in,
    output logic [`NUM_SENSORS-1:0]      start_in,   // back to granted channel only
    output logic [7:0]                   db_out,
    output logic                         rq_out,
    input  logic                         start_out
);
    localparam int                CHN_W  = $clog2(`NUM_SENSORS);
    localparam int                BCNT_W = $clog2(`STATUS_PKT_BYTES);
    localparam logic [BCNT_W-1:0] LAST   = BCNT_W'(`STATUS_PKT_BYTES - 1);

    logic [CHN_W-1:0]  sel;         // granted or last served channel
    logic [CHN_W-1:0]  nxt;         // next requester after sel
    logic              found;
    logic              granted;
    logic              streaming;   // bytes 2..4 of a packet
    logic [BCNT_W-1:0] byte_cnt;

    // search starts one past the last grant
    always_comb begin
        logic [CHN_W-1:0] cand;
        nxt   = sel;
        found = 1'b0;
        cand  = sel;
        for (int k = 1; k <= `NUM_SENSORS; k++) begin
            cand = CHN_W'((int'(sel) + k) % `NUM_SENSORS);
            if (!found && rq_in[cand]) begin
                nxt   = cand;
                found = 1'b1;
            end
        end
    end

    assign db_out   = db_in[sel];                          // straight through
    assign rq_out   = granted && rq_in[sel];
    assign start_in = (start_out && granted) ? (`NUM_SENSORS'(1) << sel) : '0;

    always_ff @(posedge mclk) begin
        if (rst) begin
            sel       <= CHN_W'(`NUM_SENSORS - 1);   // channel 0 goes first
            granted   <= 1'b0;
            streaming <= 1'b0;
            byte_cnt  <= '0;
        end else if (!granted) begin
            if (found) begin
                sel     <= nxt;
                granted <= 1'b1;
            end
        end else if (streaming) begin
            if (byte_cnt == LAST) begin             // last byte out, release
                granted   <= 1'b0;
                streaming <= 1'b0;
                byte_cnt  <= '0;
            end else begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end else if (start_out && rq_out) begin
            streaming <= 1'b1;
            byte_cnt  <= BCNT_W'(1);                // address byte taken
        end
    end

    a_start_needs_rq: assert property (@(posedge mclk) disable iff (rst)
        start_out |-> rq_out)
        else $error("status_router4: start with no request out");

endmodule

//--- source/sensors_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// sensor subsystem top
// command decode, four frame sync channels with status senders,
// and the status router
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sensors_macros.svh"

module sensors_top
    import sensors_pkg::*;
(
    input  logic                    mclk,
    input  logic                    rst,
    input  logic [7:0]              cmd_ad_in,      // byte-serial command
    input  logic                    cmd_stb_in,
    output logic [7:0]              status_ad,      // byte-serial status
    output logic                    status_rq,
    input  logic                    status_start,
    input  logic [`NUM_SENSORS-1:0] trig_in,
    input  logic [`NUM_SENSORS-1:0] line_stb,
    output logic [`NUM_SENSORS-1:0] sof_out_mclk,
    output logic [`NUM_SENSORS-1:0] sof_late_mclk
);
    logic                         wr_stb;
    logic [15:0]                  wr_addr;
    cmd_data_u                    wr_data;
    logic [`NUM_SENSORS-1:0][7:0] status_ad_chn;
    logic [`NUM_SENSORS-1:0]      status_rq_chn;
    logic [`NUM_SENSORS-1:0]      status_start_chn;

    cmd_deser cmd_deser_i (
        .mclk       (mclk),
        .rst        (rst),
        .cmd_ad_in  (cmd_ad_in),
        .cmd_stb_in (cmd_stb_in),
        .wr_stb     (wr_stb),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    for (genvar i = 0; i < `NUM_SENSORS; i++) begin : g_chn
        logic [`SENS_SYNC_BITS-1:0] frame_cnt;
        sensor_mode_t               mode;

        sensor_sync #(.CHN_NUM(i)) sensor_sync_i (
            .mclk      (mclk),
            .rst       (rst),
            .wr_stb    (wr_stb),
            .wr_addr   (wr_addr),
            .wr_data   (wr_data),
            .trig_in   (trig_in[i]),
            .line_stb  (line_stb[i]),
            .sof_out   (sof_out_mclk[i]),
            .sof_late  (sof_late_mclk[i]),
            .frame_cnt (frame_cnt),
            .mode      (mode)
        );

        sensor_status #(.CHN_NUM(i)) sensor_status_i (
            .mclk         (mclk),
            .rst          (rst),
            .sof_late     (sof_late_mclk[i]),
            .frame_cnt    (frame_cnt),
            .mode         (mode),
            .status_ad    (status_ad_chn[i]),
            .status_rq    (status_rq_chn[i]),
            .status_start (status_start_chn[i])
        );
    end

    status_router4 status_router4_i (
        .mclk      (mclk),
        .rst       (rst),
        .db_in     (status_ad_chn),
        .rq_in     (status_rq_chn),
        .start_in  (status_start_chn),
        .db_out    (status_ad),
        .rq_out    (status_rq),
        .start_out (status_start)
    );

endmodule

//--- tb/tb_sensors.sv
// ~~~~~~~~~~~~~~~~~~~~
// sensor subsystem testbench
// directed tests of register writes, frame combining, late sync,
// status packets and status arbitration
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sensors_macros.svh"

module tb_sensors;

    localparam int          NCH        = `NUM_SENSORS;
    localparam int          RQ_TIMEOUT = 400;   // cycles to wait for a status request
    localparam int          CMD_SETTLE = 10;    // 7 deser cycles + reg write, some margin
    localparam logic [31:0] EN         = 32'(1) << `SENSOR_CHN_EN_BIT;
    localparam logic [31:0] BPP16      = 32'(1) << `SENSOR_16BIT_BIT;

    logic           mclk;
    logic           rst;
    logic [7:0]     cmd_ad_in;
    logic           cmd_stb_in;
    logic [7:0]     status_ad;
    logic           status_rq;
    logic           status_start;
    logic [NCH-1:0] trig_in;
    logic [NCH-1:0] line_stb;
    logic [NCH-1:0] sof_out_mclk;
    logic [NCH-1:0] sof_late_mclk;

    integer seed   = 32'h13398a12;   // start delays for status reads
    int     errors = 0;
    int     checks = 0;
    int     sof_cnt   [NCH];          // pulses seen per channel
    int     late_cnt  [NCH];
    int     both_cnt  [NCH];          // sof and late in one cycle
    int     sof_base  [NCH];          // counts at last snapshot
    int     late_base [NCH];
    int     both_base [NCH];
    bit     rq_seen;                  // any status request so far

    sensors_top DUT (
        .mclk          (mclk),
        .rst           (rst),
        .cmd_ad_in     (cmd_ad_in),
        .cmd_stb_in    (cmd_stb_in),
        .status_ad     (status_ad),
        .status_rq     (status_rq),
        .status_start  (status_start),
        .trig_in       (trig_in),
        .line_stb      (line_stb),
        .sof_out_mclk  (sof_out_mclk),
        .sof_late_mclk (sof_late_mclk)
    );

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;      // 4 ns period
    end

    // pulse monitor, updated with nba so task reads see settled counts
    always @(posedge mclk) begin
        if (!rst) begin
            for (int i = 0; i < NCH; i++) begin
                if (sof_out_mclk[i]) sof_cnt[i] <= sof_cnt[i] + 1;
                if (sof_late_mclk[i]) late_cnt[i] <= late_cnt[i] + 1;
                if (sof_out_mclk[i] && sof_late_mclk[i]) both_cnt[i] <= both_cnt[i] + 1;
            end
            if (status_rq) rq_seen <= 1'b1;
        end
    end

    function automatic logic [15:0] reg_addr(input int chn, input int rel);
        return 16'(`SENSOR_GROUP_ADDR + chn * `SENSOR_BASE_INC + rel);
    endfunction

    // AL, AH, then data low byte first
    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] cmd;
        cmd = {data, addr};
        for (int i = 0; i < `CMD_BYTES; i++) begin
            @(posedge mclk);
            cmd_ad_in  <= cmd[8*i +: 8];
            cmd_stb_in <= (i == 0);   // strobe with AL only
        end
        @(posedge mclk);
        cmd_ad_in <= '0;
        repeat (CMD_SETTLE) @(posedge mclk);
    endtask

    task automatic pulse_trig(input logic [NCH-1:0] mask);
        @(posedge mclk);
        trig_in <= mask;
        @(posedge mclk);
        trig_in <= '0;
        repeat (2) @(posedge mclk);   // gap
    endtask

    task automatic pulse_line(input logic [NCH-1:0] mask);
        @(posedge mclk);
        line_stb <= mask;
        @(posedge mclk);
        line_stb <= '0;
        repeat (2) @(posedge mclk);
    endtask

    task automatic take_snapshot();
        for (int i = 0; i < NCH; i++) begin
            sof_base[i]  = sof_cnt[i];
            late_base[i] = late_cnt[i];
            both_base[i] = both_cnt[i];
        end
    endtask

    task automatic check_pulses(input int chn, input int exp_sof, input int exp_late,
                                input int exp_both);
        int got_sof;
        int got_late;
        int got_both;
        repeat (2) @(posedge mclk);   // let the last pulse land in the counts
        got_sof  = sof_cnt[chn] - sof_base[chn];
        got_late = late_cnt[chn] - late_base[chn];
        got_both = both_cnt[chn] - both_base[chn];
        checks++;
        if (got_sof != exp_sof || got_late != exp_late || got_both != exp_both) begin
            errors++;
            $display("ERROR %0t: ch%0d sof/late/both %0d/%0d/%0d, expected %0d/%0d/%0d",
                     $time, chn, got_sof, got_late, got_both, exp_sof, exp_late, exp_both);
        end
    endtask

    // wait for request, start after a random delay, collect 4 bytes
    task automatic read_status(output logic [31:0] pkt, output bit ok);
        int wait_cnt;
        int delay;
        pkt      = '0;
        ok       = 1'b0;
        wait_cnt = 0;
        while (!status_rq && wait_cnt < RQ_TIMEOUT) begin
            @(posedge mclk);
            wait_cnt++;
        end
        if (!status_rq) begin
            errors++;
            $display("status request did not come within %0d cycles", RQ_TIMEOUT);
            return;
        end
        delay = $random(seed) & 31;
        repeat (delay) @(posedge mclk);   // back-pressure, rq must hold
        status_start <= 1'b1;
        @(posedge mclk);                  // address byte taken here
        if (!status_rq) begin
            errors++;
            $display("status request dropped before start was given");
        end
        pkt[7:0] = status_ad;
        status_start <= 1'b0;
        for (int i = 1; i < `STATUS_PKT_BYTES; i++) begin
            @(posedge mclk);
            pkt[8*i +: 8] = status_ad;
        end
        ok = 1'b1;
    endtask

    task automatic check_packet(input logic [31:0] pkt, input bit ok, input logic [7:0] exp_addr,
                                input logic [15:0] exp_cnt, input logic [7:0] exp_flags);
        logic [31:0] exp_pkt;
        exp_pkt = {exp_flags, exp_cnt[15:8], exp_cnt[7:0], exp_addr};
        checks++;
        if (ok && pkt !== exp_pkt) begin   // timeout already counted
            errors++;
            $display("ERROR %0t: status packet %h, expected %h (flags cnt_hi cnt_lo addr)",
                     $time, pkt, exp_pkt);
        end
    endtask

    task automatic check_no_request();
        repeat (4) @(posedge mclk);
        checks++;
        if (status_rq) begin
            errors++;
            $display("ERROR %0t: status request still pending", $time);
        end
    endtask

    // nothing enabled, so pulses must stay silent
    task automatic idle_after_reset();
        take_snapshot();
        for (int k = 0; k < 3; k++) begin
            pulse_trig('1);
            pulse_line('1);
        end
        for (int i = 0; i < NCH; i++) check_pulses(i, 0, 0, 0);
        checks++;
        if (rq_seen) begin
            errors++;
            $display("ERROR %0t: status request with no channel enabled", $time);
        end
    endtask

    task automatic combine_frames();
        write_reg(reg_addr(1, `SENS_SYNC_MULT_REL), 32'd2);   // 3 triggers per frame
        write_reg(reg_addr(1, `SENSOR_CTRL_REL), EN);
        take_snapshot();
        repeat (6) pulse_trig(4'b0010);
        check_pulses(1, 2, 0, 0);       // triggers 1 and 4
        for (int i = 0; i < NCH; i++) begin
            if (i != 1) check_pulses(i, 0, 0, 0);
        end
    endtask

    task automatic late_sync();
        logic [31:0] pkt;
        bit          ok;
        write_reg(reg_addr(1, `SENS_SYNC_LATE_REL), 32'd3);
        take_snapshot();
        pulse_trig(4'b0010);            // divider back at 0, frame 3
        pulse_line(4'b0010);
        pulse_line(4'b0010);
        check_pulses(1, 1, 0, 0);       // two lines, no late sof yet
        pulse_line(4'b0010);
        check_pulses(1, 1, 1, 0);
        read_status(pkt, ok);
        check_packet(pkt, ok, 8'h22, 16'd3, 8'h01);
        write_reg(reg_addr(1, `SENS_SYNC_LATE_REL), 32'd0);
        write_reg(reg_addr(1, `SENS_SYNC_MULT_REL), 32'd0);
        write_reg(reg_addr(1, `SENSOR_CTRL_REL), 32'd0);      // clears the divider
        write_reg(reg_addr(1, `SENSOR_CTRL_REL), EN);
        take_snapshot();
        pulse_trig(4'b0010);
        check_pulses(1, 1, 1, 1);       // late 0, same cycle as sof
        read_status(pkt, ok);
        check_packet(pkt, ok, 8'h22, 16'd4, 8'h01);
    endtask

    task automatic status_packet();
        logic [31:0] pkt;
        bit          ok;
        write_reg(reg_addr(2, `SENS_SYNC_LATE_REL), 32'd1);
        write_reg(reg_addr(2, `SENSOR_CTRL_REL), EN | BPP16);
        for (int r = 1; r <= 3; r++) begin
            pulse_trig(4'b0100);        // mult 0, one frame per trigger
            pulse_line(4'b0100);
            read_status(pkt, ok);
            check_packet(pkt, ok, 8'h24, 16'(r), 8'h03);
        end
    endtask

    task automatic arbitrate_two();
        logic [31:0] pkt_a;
        logic [31:0] pkt_b;
        bit          ok_a;
        bit          ok_b;
        write_reg(reg_addr(0, `SENS_SYNC_LATE_REL), 32'd1);
        write_reg(reg_addr(3, `SENS_SYNC_LATE_REL), 32'd1);
        write_reg(reg_addr(0, `SENSOR_CTRL_REL), EN);
        write_reg(reg_addr(3, `SENSOR_CTRL_REL), EN);
        pulse_trig(4'b1001);
        pulse_line(4'b1001);            // both request in one cycle
        read_status(pkt_a, ok_a);
        read_status(pkt_b, ok_b);
        if (pkt_a[7:0] == 8'h20) begin
            check_packet(pkt_a, ok_a, 8'h20, 16'd1, 8'h01);
            check_packet(pkt_b, ok_b, 8'h26, 16'd1, 8'h01);
        end else begin
            check_packet(pkt_a, ok_a, 8'h26, 16'd1, 8'h01);
            check_packet(pkt_b, ok_b, 8'h20, 16'd1, 8'h01);
        end
    endtask

    // foreign windows and holes must not touch channel 1
    task automatic decode_windows();
        logic [31:0] pkt;
        bit          ok;
        write_reg(reg_addr(2, `SENS_SYNC_MULT_REL), 32'd5);
        write_reg(reg_addr(0, `SENS_SYNC_LATE_REL), 32'd9);
        write_reg(reg_addr(1, 1), 32'd0);          // unused offset, would disable
        write_reg(reg_addr(1, 5), 32'd7);
        write_reg(16'h0040, 32'd0);                // ch1 offset outside the group
        take_snapshot();
        pulse_trig(4'b0010);
        pulse_trig(4'b0010);
        check_pulses(1, 2, 2, 2);       // still mult 0, late 0, enabled
        read_status(pkt, ok);           // second late sof refreshed the latch
        check_packet(pkt, ok, 8'h22, 16'd6, 8'h01);
    endtask

    initial begin
        rst          = 1'b1;
        cmd_ad_in    = '0;
        cmd_stb_in   = 1'b0;
        status_start = 1'b0;
        trig_in      = '0;
        line_stb     = '0;
        rq_seen      = 1'b0;
        for (int i = 0; i < NCH; i++) begin
            sof_cnt[i]  = 0;
            late_cnt[i] = 0;
            both_cnt[i] = 0;
        end
        repeat (16) @(posedge mclk);
        rst <= 1'b0;
        repeat (4) @(posedge mclk);
        idle_after_reset();
        combine_frames();
        checks++;
        if (rq_seen) begin
            errors++;
            $display("ERROR %0t: status request before any late sof", $time);
        end
        late_sync();
        status_packet();
        arbitrate_two();
        decode_windows();
        check_no_request();
        $display("done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+common
common/sensors_pkg.sv
source/cmd_deser.sv
sensor_channel/sensor_sync.sv
sensor_channel/sensor_status.sv
source/status_router4.sv
source/sensors_top.sv
tb/tb_sensors.sv

//--- Makefile
# Verilator build and run of the sensor subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_sensors
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
